// ==== list.f ====
disp_pkg.sv
btn_pkg.sv
button_handler.sv
bcd_counter.sv
display_arbiter.sv
seven_segment.sv
press_counter_top.sv
tb_press_counter.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the press counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f list.f --top-module tb_press_counter -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== tb_press_counter.sv ====
module tb_press_counter;
    timeunit 1ns;
    timeprecision 100ps;

    import disp_pkg::*;
    import btn_pkg::*;

    localparam int HOLD_PERIOD = LOCKOUT_CYCLES + 2;   // a held button repeats this often

    logic        clk;
    logic        rst_n;
    logic        btn_a;
    logic        btn_b;
    logic        btn_clear;
    seg_t        segments;
    logic [3:0]  anode;
    logic [31:0] rng_state;
    int          model_count [2];
    int          owner;
    int          last_tie;

    press_counter_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_a     (btn_a),
        .btn_b     (btn_b),
        .btn_clear (btn_clear),
        .segments  (segments),
        .anode     (anode)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_random() % 32'(hi - lo + 1));
    endfunction

    function automatic logic [15:0] to_bcd(input int value);
        logic [15:0] bcd;
        for (int k = 0; k < 4; k++) begin
            bcd[4*k +: 4] = 4'(value % 10);
            value = value / 10;
        end
        return bcd;
    endfunction

    // own copy of the active-low digit patterns, -1 for anything else
    function automatic int seg_to_digit(input seg_t seg);
        case (seg)
            7'b100_0000: return 0;
            7'b111_1001: return 1;
            7'b010_0100: return 2;
            7'b011_0000: return 3;
            7'b001_1001: return 4;
            7'b001_0010: return 5;
            7'b000_0010: return 6;
            7'b111_1000: return 7;
            7'b000_0000: return 8;
            7'b001_0000: return 9;
            default:     return -1;
        endcase
    endfunction

    // the latest change wins, a tie goes to the channel after the last tie winner
    function automatic void update_owner(input bit changed_a, input bit changed_b);
        if (changed_a && changed_b) begin
            last_tie = (last_tie + 1) % 2;
            owner    = last_tie;
        end else if (changed_a || changed_b) begin
            owner = changed_a ? 0 : 1;
        end
    endfunction

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and display reading
    // ------------------------------------------------------------------------

    task automatic press_buttons(input bit on_a, input bit on_b, input int hold);
        int pulses;
        pulses = (hold - 1) / HOLD_PERIOD + 1;
        @(posedge clk);
        btn_a <= on_a;
        btn_b <= on_b;
        repeat (hold) @(posedge clk);
        btn_a <= 1'b0;
        btn_b <= 1'b0;
        repeat (LOCKOUT_CYCLES + 4) @(posedge clk);
        for (int i = 0; i < pulses; i++) begin
            if (on_a) model_count[0] = (model_count[0] + 1) % 10000;
            if (on_b) model_count[1] = (model_count[1] + 1) % 10000;
            update_owner(on_a, on_b);
        end
    endtask

    task automatic pulse_clear(input int hold);
        @(posedge clk);
        btn_clear <= 1'b1;
        repeat (hold) @(posedge clk);
        btn_clear <= 1'b0;
        update_owner(model_count[0] != 0, model_count[1] != 0);
        model_count[0] = 0;
        model_count[1] = 0;
    endtask

    // waits for each anode in turn and assembles the four digits as BCD
    task automatic expect_display(input logic [15:0] exp);
        logic [15:0] value;
        logic [3:0]  code;
        int          digit;
        int          waited;
        repeat (3 + 4 * DIGIT_TICKS) @(posedge clk);
        for (int k = 0; k < 4; k++) begin
            code   = ~(4'b0001 << k);
            waited = 0;
            @(negedge clk);
            while (anode !== code) begin
                if (waited > 4 * DIGIT_TICKS) begin
                    $display("%0t ns: anode never reached %b during a display read", $time, code);
                    stop_with_failure();
                end
                waited++;
                @(negedge clk);
            end
            digit = seg_to_digit(segments);
            if (digit < 0) begin
                $display("%0t ns: segment pattern %b is not a decimal digit", $time, segments);
                stop_with_failure();
            end
            value[4*k +: 4] = 4'(digit);
        end
        check_value("shown", value, exp);
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [3:0] prev_anode;
        logic [3:0] exp_anode;
        bit         pick;
        int         changes;
        int         waited;
        int         remaining;
        int         run;
        rng_state      = 32'd87914;
        model_count[0] = 0;
        model_count[1] = 0;
        owner          = 0;
        last_tie       = 0;
        rst_n          = 1'b0;
        btn_a          = 1'b0;
        btn_b          = 1'b0;
        btn_clear      = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // scan order after reset starts at digit 0
        @(negedge clk);
        check_value("anode", anode, 4'b1110);
        prev_anode = anode;
        changes    = 0;
        waited     = 0;
        while (changes < 8) begin
            if (waited > 9 * DIGIT_TICKS) begin
                $display("%0t ns: anode stopped scanning", $time);
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
            if (anode !== prev_anode) begin
                changes++;
                exp_anode = ~(4'b0001 << (changes % 4));
                check_value("anode", anode, exp_anode);
                prev_anode = anode;
            end
        end
        expect_display(16'h0000);

        for (int n = 0; n < 12; n++) begin
            pick = (next_random() % 2 == 0);
            press_buttons(pick, !pick, rand_range(1, 30));
            expect_display(to_bcd(model_count[owner]));
        end
        press_buttons(1'b0, 1'b1, rand_range(1, 30));
        expect_display(to_bcd(model_count[1]));
        press_buttons(1'b1, 1'b0, rand_range(1, 30));
        expect_display(to_bcd(model_count[0]));   // ownership is back with channel A

        // make the channels differ so the tie winner is visible
        if (model_count[0] == model_count[1]) press_buttons(1'b1, 1'b0, 5);
        press_buttons(1'b1, 1'b1, rand_range(1, 30));
        expect_display(to_bcd(model_count[1]));
        press_buttons(1'b1, 1'b1, rand_range(1, 30));
        expect_display(to_bcd(model_count[0]));

        // long held runs bring channel A up to 9999
        remaining = 9999 - model_count[0];
        while (remaining > 0) begin
            run = rand_range(1, 400);
            if (run > remaining) run = remaining;
            press_buttons(1'b1, 1'b0, run * HOLD_PERIOD);
            remaining = remaining - run;
        end
        expect_display(16'h9999);
        press_buttons(1'b1, 1'b0, rand_range(1, 30));
        expect_display(16'h0000);
        press_buttons(1'b1, 1'b0, rand_range(1, 30));
        expect_display(16'h0001);

        pulse_clear(rand_range(1, 4));
        expect_display(16'h0000);
        pick = (next_random() % 2 == 0);
        press_buttons(pick, !pick, rand_range(1, 30));
        expect_display(16'h0001);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== press_counter_top.sv ====
module press_counter_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       btn_a,
    input  logic       btn_b,
    input  logic       btn_clear,
    output logic [6:0] segments,
    output logic [3:0] anode
);
    import disp_pkg::*;

    logic [NUM_SRC-1:0] btn;
    logic [NUM_SRC-1:0] press;
    logic [NUM_SRC-1:0] changed;
    bcd4_t              count [NUM_SRC];
    bcd4_t              shown;
    seg_t               seg;

    assign btn = {btn_b, btn_a};

    // one press handler and one counter per channel
    for (genvar i = 0; i < NUM_SRC; i++) begin : ch
        button_handler u_handler (
            .clk    (clk),
            .rst_n  (rst_n),
            .button (btn[i]),
            .press  (press[i])
        );

        bcd_counter u_counter (
            .clk     (clk),
            .rst_n   (rst_n),
            .incr    (press[i]),
            .clear   (btn_clear),
            .count   (count[i]),
            .changed (changed[i])
        );
    end

    display_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .count_a   (count[0]),
        .count_b   (count[1]),
        .changed_a (changed[0]),
        .changed_b (changed[1]),
        .shown     (shown)
    );

    seven_segment u_display (
        .clk      (clk),
        .rst_n    (rst_n),
        .shown    (shown),
        .segments (seg),
        .anode    (anode)
    );

    assign segments = seg;

endmodule

// ==== seven_segment.sv ====
module seven_segment (
    input  logic            clk,
    input  logic            rst_n,
    input  disp_pkg::bcd4_t shown,
    output disp_pkg::seg_t  segments,
    output logic [3:0]      anode
);
    import disp_pkg::*;

    logic [SCAN_W-1:0] scan_timer;
    logic [1:0]        digit;
    logic [3:0]        nibble;

    // ------------------------------------------------------------------------
    // scan timer
    // ------------------------------------------------------------------------

    // each digit stays lit for DIGIT_TICKS cycles, a full scan is four of those
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_timer <= '0;
            digit      <= 2'd0;
        end else if (scan_timer == SCAN_W'(DIGIT_TICKS - 1)) begin
            scan_timer <= '0;
            digit      <= digit + 2'd1;            // 3 wraps back to 0
        end else begin
            scan_timer <= scan_timer + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // anode select and decode
    // ------------------------------------------------------------------------

    always_comb begin
        case (digit)
            2'd0: begin
                anode  = 4'b1110;
                nibble = shown[0];
            end
            2'd1: begin
                anode  = 4'b1101;
                nibble = shown[1];
            end
            2'd2: begin
                anode  = 4'b1011;
                nibble = shown[2];
            end
            2'd3: begin
                anode  = 4'b0111;
                nibble = shown[3];
            end
            default: begin
                anode  = 4'b1111;                  // all digits dark
                nibble = shown[0];
            end
        endcase
    end

    assign segments = bcd_to_seg(nibble);

endmodule

// ==== display_arbiter.sv ====
module display_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  disp_pkg::bcd4_t count_a,
    input  disp_pkg::bcd4_t count_b,
    input  logic            changed_a,
    input  logic            changed_b,
    output disp_pkg::bcd4_t shown
);
    import disp_pkg::*;

    typedef logic [$clog2(NUM_SRC)-1:0] src_t;

    bcd4_t              src_count [NUM_SRC];
    logic [NUM_SRC-1:0] src_changed;
    src_t               owner;
    src_t               owner_next;
    src_t               last_tie;                  // winner of the last tie
    src_t               tie_next;

    assign src_count[0] = count_a;
    assign src_count[1] = count_b;
    assign src_changed  = {changed_b, changed_a};

    // the channel after the last tie winner gets the next tie
    assign tie_next = (last_tie == src_t'(NUM_SRC - 1)) ? '0 : last_tie + 1'b1;

    // ------------------------------------------------------------------------
    // ownership
    // ------------------------------------------------------------------------

    always_comb begin
        owner_next = owner;
        if (&src_changed) begin
            owner_next = tie_next;
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (src_changed[i]) begin
                    owner_next = src_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner    <= '0;
            last_tie <= '0;                         // so the first tie goes to channel 1
        end else begin
            owner <= owner_next;
            if (&src_changed) begin
                last_tie <= tie_next;
            end
        end
    end

    // follows the owner's live count, lagging it by one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shown <= '0;
        end else begin
            shown <= src_count[owner_next];
        end
    end

endmodule

// ==== bcd_counter.sv ====
module bcd_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            incr,
    input  logic            clear,
    output disp_pkg::bcd4_t count,
    output logic            changed
);
    import disp_pkg::*;

    bcd4_t count_next;
    logic  carry;

    // ------------------------------------------------------------------------
    // ripple carry increment, 9999 rolls over to 0000
    // ------------------------------------------------------------------------

    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (!carry) begin
                count_next[i] = count[i];
            end else if (count[i] == 4'd9) begin
                count_next[i] = 4'd0;           // carry moves on to the next digit
            end else begin
                count_next[i] = count[i] + 4'd1;
                carry         = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // count register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            changed <= 1'b0;
        end else if (clear) begin
            // clear wins over incr and is only a change if something was shown
            count   <= '0;
            changed <= (count != '0);
        end else if (incr) begin
            count   <= count_next;
            changed <= 1'b1;
        end else begin
            changed <= 1'b0;
        end
    end

endmodule

// ==== button_handler.sv ====
module button_handler (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic press
);
    import btn_pkg::*;

    btn_state_t        state;
    btn_state_t        state_next;
    logic [LOCK_W-1:0] lock_timer;

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (button) begin
                    state_next = FIRE;
                end
            end
            FIRE: begin
                state_next = LOCK;
            end
            LOCK: begin
                if (lock_timer == '0) begin
                    state_next = IDLE;                 // held or not, go back
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // state and lockout timer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            lock_timer <= '0;
        end else begin
            state <= state_next;
            if (state == FIRE) begin
                // counts down to zero, so LOCK spans LOCKOUT_CYCLES cycles
                lock_timer <= LOCK_W'(LOCKOUT_CYCLES - 1);
            end else if (state == LOCK && lock_timer != '0) begin
                lock_timer <= lock_timer - 1'b1;
            end
        end
    end

    assign press = (state == FIRE);    // one cycle per press

endmodule

// ==== btn_pkg.sv ====
package btn_pkg;

    // ------------------------------------------------------------------------
    // press handler
    // ------------------------------------------------------------------------

    // IDLE waits for the button, FIRE is the single pulse cycle,
    // LOCK ignores the button until the lockout timer runs out
    typedef enum logic [1:0] {
        IDLE,
        FIRE,
        LOCK
    } btn_state_t;

    localparam int LOCKOUT_CYCLES = 40;        // cycles ignored after a pulse
    localparam int LOCK_W         = $clog2(LOCKOUT_CYCLES);

endpackage

// ==== disp_pkg.sv ====
package disp_pkg;

    // ------------------------------------------------------------------------
    // display value and segment types
    // ------------------------------------------------------------------------

    // four BCD digits, digit 0 sits in the low nibble
    typedef logic [3:0][3:0] bcd4_t;

    typedef logic [6:0] seg_t;                 // active low, g down to a

    localparam int NUM_SRC     = 2;            // channels sharing one display
    localparam int DIGIT_TICKS = 25;           // cycles each digit stays lit
    localparam int SCAN_W      = $clog2(DIGIT_TICKS);

    // ------------------------------------------------------------------------
    // digit decode
    // ------------------------------------------------------------------------

    // hex A to F are kept so a corrupt nibble is still visible on the board
    function automatic seg_t bcd_to_seg(input logic [3:0] value);
        seg_t seg;
        case (value)
            4'h0: seg = 7'b100_0000;
            4'h1: seg = 7'b111_1001;
            4'h2: seg = 7'b010_0100;
            4'h3: seg = 7'b011_0000;
            4'h4: seg = 7'b001_1001;
            4'h5: seg = 7'b001_0010;
            4'h6: seg = 7'b000_0010;
            4'h7: seg = 7'b111_1000;
            4'h8: seg = 7'b000_0000;
            4'h9: seg = 7'b001_0000;
            4'ha: seg = 7'b000_1000;
            4'hb: seg = 7'b000_0011;
            4'hc: seg = 7'b100_0110;
            4'hd: seg = 7'b010_0001;
            4'he: seg = 7'b000_0110;
            default: seg = 7'b000_1110;
        endcase
        return seg;
    endfunction

endpackage
